//--- include/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// Width of a fetch byte address
`define ICACHE_ADDR_BITS 32

// Width of one instruction word
`define ICACHE_WORD_BITS 32

// Byte select inside a word, dropped by the cache
`define ICACHE_BYTE_BITS 2

// Words in one line, 16 bytes
`define ICACHE_LINE_WORDS 4

// Word index inside a line
`define ICACHE_WORD_OFFSET_BITS 2

// Line index, 16 lines in the direct-mapped array
`define ICACHE_INDEX_BITS 4

// Number of lines follows from the index width
`define ICACHE_LINES (1 << `ICACHE_INDEX_BITS)

// The tag is what is left of the address above index and offsets, 24 bits
`define ICACHE_TAG_BITS \
	(`ICACHE_ADDR_BITS - `ICACHE_INDEX_BITS - `ICACHE_WORD_OFFSET_BITS - `ICACHE_BYTE_BITS)

`endif

//--- src/icache_pkg.sv
`default_nettype none

`include "icache_consts.svh"

package icache_pkg;

	// Fetch byte address from the CPU
	typedef logic [`ICACHE_ADDR_BITS-1:0] addr_t;

	// One instruction word
	typedef logic [`ICACHE_WORD_BITS-1:0] word_t;

	typedef logic [`ICACHE_TAG_BITS-1:0] tag_t;

	typedef logic [`ICACHE_INDEX_BITS-1:0] index_t;

	typedef logic [`ICACHE_WORD_OFFSET_BITS-1:0] word_offset_t;

	// A whole line with word 0 in the low bits
	typedef logic [`ICACHE_LINE_WORDS*`ICACHE_WORD_BITS-1:0] line_t;

	// One bit wider than a word offset so it can hold the full line count
	typedef logic [`ICACHE_WORD_OFFSET_BITS:0] beat_count_t;

	// Fill controller states
	typedef enum logic {
		fill_idle,
		fill_read_mem
	} fill_state_t;

	// Decoded view of a fetch address, tag in the top bits
	typedef struct packed {
		tag_t                         tag;
		index_t                       index;
		word_offset_t                 word_offset;
		logic [`ICACHE_BYTE_BITS-1:0] byte_sel;
	} fetch_addr_t;

endpackage

`default_nettype wire

//--- src/icache_fill_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_fill_ctrl (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    hit,
	input  logic                    cpu_req,
	input  icache_pkg::fetch_addr_t fetch,
	input  logic                    mem_addr_ok,
	input  logic                    mem_data_ok,
	input  icache_pkg::word_t       mem_rdata,
	output logic                    mem_req,
	output icache_pkg::addr_t       mem_addr,
	output icache_pkg::line_t       fill_line,
	output logic                    fill_done,
	output logic                    busy
);

	import icache_pkg::*;

	fill_state_t  state;
	beat_count_t  beat_count;
	word_offset_t beat_slot;
	fetch_addr_t  line_base;
	logic         start_fill;
	logic         line_full;
	logic         take_beat;

	// A fetch that misses while idle opens a line fill
	assign start_fill = (state == fill_idle) && cpu_req && !hit;

	// All words of the line have arrived
	assign line_full = (beat_count == beat_count_t'(`ICACHE_LINE_WORDS));

	assign take_beat = (state == fill_read_mem) && mem_data_ok && !line_full;

	assign beat_slot = beat_count[`ICACHE_WORD_OFFSET_BITS-1:0];

	// Memory is asked for the whole line starting at word 0
	always_comb begin
		line_base = fetch;
		line_base.word_offset = '0;
		line_base.byte_sel = '0;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fill_idle;
		end else begin
			case (state)
				fill_idle: begin
					if (start_fill) begin
						state <= fill_read_mem;
					end
				end
				fill_read_mem: begin
					// Stay one more cycle after the last beat so fill_done can be seen
					if (line_full) begin
						state <= fill_idle;
					end
				end
				default: begin
					state <= fill_idle;
				end
			endcase
		end
	end

	// The request level holds until the memory takes the address
	always_ff @(posedge clk) begin
		if (reset) begin
			mem_req <= 1'b0;
		end else if (start_fill) begin
			mem_req <= 1'b1;
		end else if (mem_req && mem_addr_ok) begin
			mem_req <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start_fill) begin
			mem_addr <= addr_t'(line_base);
		end
	end

	// Beat counter, held at zero whenever the controller is idle
	always_ff @(posedge clk) begin
		if (reset || state == fill_idle) begin
			beat_count <= '0;
		end else if (take_beat) begin
			beat_count <= beat_count + 1'b1;
		end
	end

	// Each returning word goes to its own slot of the line buffer
	always_ff @(posedge clk) begin
		if (take_beat) begin
			fill_line[beat_slot*`ICACHE_WORD_BITS +: `ICACHE_WORD_BITS] <= mem_rdata;
		end
	end

	assign fill_done = (state == fill_read_mem) && line_full;
	assign busy = (state == fill_read_mem);

endmodule

`default_nettype wire

//--- src/icache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_tag_store (
	input  logic                    clk,
	input  logic                    reset,
	input  icache_pkg::fetch_addr_t fetch,
	input  logic                    fill_done,
	output logic                    hit
);

	import icache_pkg::*;

	// One valid bit and one tag per line
	logic [`ICACHE_LINES-1:0] valid;
	tag_t                     tags [`ICACHE_LINES];

	tag_t stored_tag;
	logic line_valid;
	logic tag_match;

	// Lookup at the index of the current fetch
	assign stored_tag = tags[fetch.index];
	assign line_valid = valid[fetch.index];

	assign tag_match = (stored_tag == fetch.tag);

	// Combinational so the controller can react in the same cycle
	assign hit = line_valid && tag_match;

	// Valid bits start clear, every line begins as a miss
	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
		end else if (fill_done) begin
			valid[fetch.index] <= 1'b1;
		end
	end

	// The fetch address is held through the fill, so its index and tag are
	// still the ones that started it
	always_ff @(posedge clk) begin
		if (fill_done) begin
			tags[fetch.index] <= fetch.tag;
		end
	end

endmodule

`default_nettype wire

//--- src/icache_data_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_data_store (
	input  logic                    clk,
	input  logic                    reset,
	input  icache_pkg::fetch_addr_t fetch,
	input  logic                    cpu_req,
	input  logic                    hit,
	input  logic                    busy,
	input  logic                    fill_done,
	input  icache_pkg::line_t       fill_line,
	output icache_pkg::word_t       cpu_rdata,
	output logic                    cpu_data_ok
);

	import icache_pkg::*;

	line_t lines [`ICACHE_LINES];

	line_t read_line;
	word_t read_word;
	logic  issued;
	logic  serve;

	// Word select from the line at the fetch index
	assign read_line = lines[fetch.index];
	assign read_word = read_line[fetch.word_offset*`ICACHE_WORD_BITS +: `ICACHE_WORD_BITS];

	// A request is answered once, and never while a fill is running
	assign serve = cpu_req && hit && !busy && !issued;

	// Whole line written at once when the fill completes
	always_ff @(posedge clk) begin
		if (fill_done) begin
			lines[fetch.index] <= fill_line;
		end
	end

	// Re-armed only when the CPU drops its request
	always_ff @(posedge clk) begin
		if (reset || !cpu_req) begin
			issued <= 1'b0;
		end else if (serve) begin
			issued <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cpu_data_ok <= 1'b0;
		end else begin
			cpu_data_ok <= serve;
		end
	end

	always_ff @(posedge clk) begin
		if (serve) begin
			cpu_rdata <= read_word;
		end
	end

endmodule

`default_nettype wire

//--- src/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top (
	input  logic              clk,
	input  logic              reset,
	input  logic              cpu_req,
	input  icache_pkg::addr_t cpu_addr,
	output icache_pkg::word_t cpu_rdata,
	output logic              cpu_data_ok,
	output logic              mem_req,
	output icache_pkg::addr_t mem_addr,
	input  logic              mem_addr_ok,
	input  logic              mem_data_ok,
	input  icache_pkg::word_t mem_rdata
);

	import icache_pkg::*;

	fetch_addr_t fetch;
	logic        hit;
	logic        busy;
	logic        fill_done;
	line_t       fill_line;

	// Split the fetch address into tag, index and offsets
	assign fetch = fetch_addr_t'(cpu_addr);

	// Miss handling and the memory side
	icache_fill_ctrl fill_ctrl0 (
		.clk         (clk),
		.reset       (reset),
		.hit         (hit),
		.cpu_req     (cpu_req),
		.fetch       (fetch),
		.mem_addr_ok (mem_addr_ok),
		.mem_data_ok (mem_data_ok),
		.mem_rdata   (mem_rdata),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.fill_line   (fill_line),
		.fill_done   (fill_done),
		.busy        (busy)
	);

	icache_tag_store tag_store0 (
		.clk       (clk),
		.reset     (reset),
		.fetch     (fetch),
		.fill_done (fill_done),
		.hit       (hit)
	);

	// Line storage and the CPU answer
	icache_data_store data_store0 (
		.clk         (clk),
		.reset       (reset),
		.fetch       (fetch),
		.cpu_req     (cpu_req),
		.hit         (hit),
		.busy        (busy),
		.fill_done   (fill_done),
		.fill_line   (fill_line),
		.cpu_rdata   (cpu_rdata),
		.cpu_data_ok (cpu_data_ok)
	);

endmodule

`default_nettype wire

//--- testbench/icache_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_mem_model (
	input  logic              clk,
	input  logic              reset,
	input  logic              mem_req,
	input  icache_pkg::addr_t mem_addr,
	output logic              mem_addr_ok,
	output logic              mem_data_ok,
	output icache_pkg::word_t mem_rdata,
	output int unsigned       req_count
);

	import icache_pkg::*;

	typedef enum logic [1:0] {
		mem_idle,
		mem_addr_wait,
		mem_beats
	} mem_phase_t;

	mem_phase_t  phase;
	logic [1:0]  wait_left;
	int unsigned beat;
	addr_t       base;
	logic [31:0] lfsr;

	// Taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Memory contents are a fixed function of the word address
	function automatic word_t word_at(input addr_t a);
		return a ^ 32'h5a5a0000;
	endfunction

	// Two bits, one LFSR step each, give a delay of 0 to 3 cycles
	task automatic draw_delay(output logic [1:0] d);
		for (int b = 0; b < 2; b++) begin
			lfsr = lfsr_next(lfsr);
			d[b] = lfsr[0];
		end
	endtask

	always @(posedge clk) begin
		logic [1:0] d;
		if (reset) begin
			lfsr = 32'h7dc7d484;
			phase <= mem_idle;
			wait_left <= 2'd0;
			beat <= 0;
			base <= '0;
			mem_addr_ok <= 1'b0;
			mem_data_ok <= 1'b0;
			mem_rdata <= '0;
			req_count <= 0;
		end else begin
			mem_addr_ok <= 1'b0;
			mem_data_ok <= 1'b0;
			case (phase)
				mem_idle: begin
					if (mem_req) begin
						draw_delay(d);
						wait_left <= d;
						base <= mem_addr;
						beat <= 0;
						phase <= mem_addr_wait;
					end
				end
				mem_addr_wait: begin
					if (wait_left == 2'd0) begin
						mem_addr_ok <= 1'b1;
						req_count <= req_count + 1;
						draw_delay(d);
						wait_left <= d;
						phase <= mem_beats;
					end else begin
						wait_left <= wait_left - 2'd1;
					end
				end
				default: begin
					// Beats go out word 0 first, with a fresh gap before each
					if (wait_left == 2'd0) begin
						mem_data_ok <= 1'b1;
						mem_rdata <= word_at(base + 4 * beat);
						draw_delay(d);
						wait_left <= d;
						beat <= beat + 1;
						if (beat == `ICACHE_LINE_WORDS - 1) begin
							phase <= mem_idle;
						end
					end else begin
						wait_left <= wait_left - 2'd1;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- testbench/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

	import icache_pkg::*;

	localparam int CYCLES_PER_TEST = 40;
	localparam int CYCLE_MARGIN = 20;

	logic        clk = 1'b0;
	logic        reset;
	logic        cpu_req;
	addr_t       cpu_addr;
	word_t       cpu_rdata;
	logic        cpu_data_ok;
	logic        mem_req;
	addr_t       mem_addr;
	logic        mem_addr_ok;
	logic        mem_data_ok;
	word_t       mem_rdata;
	int unsigned req_count;

	logic [8*24-1:0] test_names[$];
	addr_t           test_addrs[$];
	word_t           test_words[$];
	logic            test_misses[$];

	int unsigned cycle_count = 0;
	int unsigned cycle_limit = 0;
	int          pass_count;
	int          fail_count;
	logic        test_ok;

	icache_top dut0 (
		.clk         (clk),
		.reset       (reset),
		.cpu_req     (cpu_req),
		.cpu_addr    (cpu_addr),
		.cpu_rdata   (cpu_rdata),
		.cpu_data_ok (cpu_data_ok),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_addr_ok (mem_addr_ok),
		.mem_data_ok (mem_data_ok),
		.mem_rdata   (mem_rdata)
	);

	icache_mem_model mem0 (
		.clk         (clk),
		.reset       (reset),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_addr_ok (mem_addr_ok),
		.mem_data_ok (mem_data_ok),
		.mem_rdata   (mem_rdata),
		.req_count   (req_count)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("ERROR: the cache did not answer within %0d cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic compare_word(input logic [8*24-1:0] name, input word_t expected,
			input word_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %0s word: expected %08h, actual %08h", name, expected, actual);
			test_ok = 1'b0;
		end
	endtask

	task automatic compare_miss(input logic [8*24-1:0] name, input logic expected,
			input logic actual);
		if (actual !== expected) begin
			$display("MISMATCH %0s miss: expected %0b, actual %0b", name, expected, actual);
			test_ok = 1'b0;
		end
	endtask

	// Lines starting with a lone # token are column notes
	task automatic load_tests();
		int              fd;
		int              n;
		int              c;
		logic [8*24-1:0] tok;
		addr_t           a;
		word_t           w;
		logic            m;
		fd = $fopen("testbench/icache_testdata.txt", "r");
		if (fd == 0) begin
			$display("ERROR: could not open the test data file");
			fail_count++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fscanf(fd, "%s", tok);
			if (n != 1) begin
				break;
			end
			if (tok[7:0] == "#" && tok[8*24-1:8] == '0) begin
				c = $fgetc(fd);
				while (c != 10 && c != -1) begin
					c = $fgetc(fd);
				end
			end else begin
				n = $fscanf(fd, "%h %h %b", a, w, m);
				if (n != 3) begin
					$display("ERROR: the data file line for %0s is malformed", tok);
					fail_count++;
					break;
				end
				test_names.push_back(tok);
				test_addrs.push_back(a);
				test_words.push_back(w);
				test_misses.push_back(m);
			end
		end
		$fclose(fd);
	endtask

	task automatic run_test(input int i);
		int unsigned req_before;
		int unsigned req_delta;
		word_t       got_word;
		@(posedge clk);
		test_ok = 1'b1;
		req_before = req_count;
		cpu_req <= 1'b1;
		cpu_addr <= test_addrs[i];
		@(posedge clk);
		while (!cpu_data_ok) begin
			@(posedge clk);
		end
		got_word = cpu_rdata;
		cpu_req <= 1'b0;
		@(posedge clk);
		if (cpu_data_ok) begin
			$display("ERROR: %0s was answered more than once", test_names[i]);
			test_ok = 1'b0;
		end
		req_delta = req_count - req_before;
		if (req_delta > 1) begin
			$display("ERROR: %0s made %0d memory requests", test_names[i], req_delta);
			test_ok = 1'b0;
		end
		compare_word(test_names[i], test_words[i], got_word);
		compare_miss(test_names[i], test_misses[i], req_delta != 0);
		if (test_ok) begin
			$display("ok %0s addr %08h word %08h", test_names[i], test_addrs[i], got_word);
			pass_count++;
		end else begin
			fail_count++;
		end
	endtask

	initial begin
		reset <= 1'b1;
		cpu_req <= 1'b0;
		cpu_addr <= '0;
		pass_count = 0;
		fail_count = 0;
		load_tests();
		cycle_limit = CYCLES_PER_TEST * test_addrs.size() + CYCLE_MARGIN;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < test_addrs.size(); i++) begin
			run_test(i);
		end
		if (test_addrs.size() == 0) begin
			$display("ERROR: no tests were loaded");
			fail_count++;
		end
		$display("%0d tests passed, %0d tests failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/icache_testdata.txt
# name fetch_addr(hex) expected_word(hex) expected_miss(bin)
# word = addr ^ 5a5a0000, miss from a direct-mapped model of 16 lines of 16 bytes
cold_a_w0 00001000 5a5a1000 1
hit_a_w1 00001004 5a5a1004 0
hit_a_w2 00001008 5a5a1008 0
hit_a_w3 0000100c 5a5a100c 0
cold_c_w3 0000202c 5a5a202c 1
hit_c_w0 00002020 5a5a2020 0
hit_c_w1 00002024 5a5a2024 0
hit_c_w2 00002028 5a5a2028 0
cold_d_w2 00003058 5a5a3058 1
hit_d_w1 00003054 5a5a3054 0
evict_b_w0 00045000 5a5e5000 1
keep_c_w1 00002024 5a5a2024 0
evict_a_w1 00001004 5a5a1004 1
hit_a_w3_again 0000100c 5a5a100c 0
evict_b_w2 00045008 5a5e5008 1
keep_d_w0 00003050 5a5a3050 0
evict_a_w0 00001000 5a5a1000 1
cold_e_w1 800001f4 da5a01f4 1
hit_e_w0 800001f0 da5a01f0 0
cold_f_w0 deadbee0 84f7bee0 1
hit_f_w3 deadbeec 84f7beec 0
cold_g_w2 12345678 486e5678 1
hit_g_w1 12345674 486e5674 0
evict_h_w3 0000f0fc 5a5af0fc 1
evict_e_w3 800001fc da5a01fc 1
keep_f_w1 deadbee4 84f7bee4 0

//--- project.f
+incdir+include
src/icache_pkg.sv
src/icache_fill_ctrl.sv
src/icache_tag_store.sv
src/icache_data_store.sv
src/icache_top.sv
testbench/icache_mem_model.sv
testbench/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it into sim.log and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f project.f --top-module icache_tb -o icache_sim \
	&& ./obj_dir/icache_sim > sim.log 2>&1 \
	|| { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TEST RESULT: PASS" sim.log && exit 0 || exit 1
